// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing
TOP = tb_fprint_compare
FILELIST = fprint_compare.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf obj_dir

// File: fprint_compare.f
rtl/fprint_pkg.sv
rtl/csr_registers.sv
rtl/fprint_comparator.sv
rtl/fprint_compare_top.sv
verification/fprint_checker.sv
verification/tb_fprint_compare.sv

// File: rtl/csr_registers.sv
module csr_registers (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [fprint_pkg::csr_addr_width-1:0]  csr_address,
	input  logic                                   csr_read,
	input  logic                                   csr_write,
	input  logic [fprint_pkg::data_width-1:0]      csr_writedata,
	output logic [fprint_pkg::data_width-1:0]      csr_readdata,
	output logic                                   csr_waitrequest,
	input  logic [fprint_pkg::task_id_width-1:0]   lookup_task_id,
	input  logic [fprint_pkg::core_id_width-1:0]   lookup_core_id,
	output logic [fprint_pkg::logical_id_width-1:0] lookup_logical_id,
	output logic                                   comparator_nmr,
	input  logic                                   status_write,
	input  logic [fprint_pkg::task_id_width-1:0]   status_task_id,
	input  logic                                   status_mismatch,
	input  logic [fprint_pkg::logical_id_width-1:0] status_logical_id,
	output logic                                   csr_status_ack,
	output logic                                   irq
);

	fprint_pkg::csr_state_e state;

	logic [fprint_pkg::data_width-1:0]     exception_reg;
	logic [fprint_pkg::task_count-1:0]     success_reg;
	// task n at bits 2n+1:2n
	logic [2*fprint_pkg::task_count-1:0]   fail_reg;
	logic [fprint_pkg::task_count-1:0]     nmr_flags;

	// physical core per task with one table per logical slot
	logic [fprint_pkg::core_id_width-1:0]  assign_tbl [3][fprint_pkg::task_count] =
		'{default: '0};

	logic [fprint_pkg::task_id_width-1:0]    wr_task;
	logic [fprint_pkg::logical_id_width-1:0] wr_logical;
	logic [fprint_pkg::core_id_width-1:0]    wr_physical;

	assign wr_task = csr_writedata[fprint_pkg::wr_task_lsb +: fprint_pkg::task_id_width];
	assign wr_logical = csr_writedata[fprint_pkg::wr_logical_lsb +: fprint_pkg::logical_id_width];
	assign wr_physical = csr_writedata[fprint_pkg::wr_physical_lsb +: fprint_pkg::core_id_width];

	assign irq = exception_reg[fprint_pkg::exc_irq_bit];
	assign csr_waitrequest = (state != fprint_pkg::csr_done);
	assign csr_status_ack = (state == fprint_pkg::status_ack);

	// control FSM with host requests ahead of status reports
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fprint_pkg::csr_idle;
		end else begin
			case (state)
				fprint_pkg::csr_idle: begin
					if (csr_write) begin
						case (csr_address)
							fprint_pkg::reg_exception:   state <= fprint_pkg::csr_regs_write;
							fprint_pkg::reg_core_assign: state <= fprint_pkg::csr_assign_write;
							fprint_pkg::reg_nmr:         state <= fprint_pkg::csr_nmr_write;
							// unmapped write is never acknowledged
							default:                     state <= fprint_pkg::csr_idle;
						endcase
					end else if (csr_read) begin
						state <= fprint_pkg::csr_read;
					end else if (status_write && !irq) begin
						state <= fprint_pkg::status_capture;
					end
				end
				fprint_pkg::csr_regs_write,
				fprint_pkg::csr_assign_write,
				fprint_pkg::csr_nmr_write,
				fprint_pkg::csr_read: begin
					state <= fprint_pkg::csr_done;
				end
				fprint_pkg::status_capture: begin
					state <= fprint_pkg::status_ack;
				end
				default: begin
					state <= fprint_pkg::csr_idle;
				end
			endcase
		end
	end

	// read data is valid while in csr_done
	always_ff @(posedge clk) begin
		if (state == fprint_pkg::csr_read) begin
			case (csr_address)
				fprint_pkg::reg_exception: csr_readdata <= exception_reg;
				fprint_pkg::reg_success: begin
					csr_readdata <= {{(fprint_pkg::data_width - fprint_pkg::task_count){1'b0}},
						success_reg};
				end
				fprint_pkg::reg_fail:      csr_readdata <= fail_reg;
				default:                   csr_readdata <= '0;
			endcase
		end
	end

	// exception, success and fail
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exception_reg <= '0;
			success_reg <= '0;
			fail_reg <= '1;
		end else if (state == fprint_pkg::csr_regs_write) begin
			exception_reg <= csr_writedata;
			success_reg <= '0;
			fail_reg <= '1;
		end else if (state == fprint_pkg::status_capture) begin
			exception_reg[fprint_pkg::exc_irq_bit] <= 1'b1;
			exception_reg[fprint_pkg::exc_mismatch_bit] <= status_mismatch;
			exception_reg[fprint_pkg::exc_task_lsb +: fprint_pkg::task_id_width] <= status_task_id;
			success_reg[status_task_id] <= !status_mismatch;
			if (status_mismatch) begin
				fail_reg[2*status_task_id +: 2] <= status_logical_id;
			end
		end
	end

	// writes to slot 3 are dropped
	always_ff @(posedge clk) begin
		if (state == fprint_pkg::csr_assign_write &&
				wr_logical != fprint_pkg::logical_unassigned) begin
			assign_tbl[wr_logical][wr_task] <= wr_physical;
		end
	end

	// reverse lookup where the lowest matching slot wins
	always_comb begin
		if (assign_tbl[0][lookup_task_id] == lookup_core_id) begin
			lookup_logical_id = 2'd0;
		end else if (assign_tbl[1][lookup_task_id] == lookup_core_id) begin
			lookup_logical_id = 2'd1;
		end else if (assign_tbl[2][lookup_task_id] == lookup_core_id) begin
			lookup_logical_id = 2'd2;
		end else begin
			lookup_logical_id = fprint_pkg::logical_unassigned;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			nmr_flags <= '0;
		end else if (state == fprint_pkg::csr_nmr_write) begin
			nmr_flags[wr_task] <= csr_writedata[0];
		end
	end

	assign comparator_nmr = nmr_flags[lookup_task_id];

endmodule

// File: rtl/fprint_comparator.sv
module fprint_comparator #(
	parameter int fprint_width = 32
) (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    fprint_valid,
	input  logic [fprint_pkg::task_id_width-1:0]    fprint_task_id,
	input  logic [fprint_pkg::core_id_width-1:0]    fprint_core_id,
	input  logic [fprint_width-1:0]                 fprint_data,
	output logic [fprint_pkg::task_id_width-1:0]    lookup_task_id,
	output logic [fprint_pkg::core_id_width-1:0]    lookup_core_id,
	input  logic [fprint_pkg::logical_id_width-1:0] lookup_logical_id,
	input  logic                                    comparator_nmr,
	output logic                                    status_write,
	output logic [fprint_pkg::task_id_width-1:0]    status_task_id,
	output logic                                    status_mismatch,
	output logic [fprint_pkg::logical_id_width-1:0] status_logical_id,
	input  logic                                    csr_status_ack
);

	fprint_pkg::cmp_state_e state;

	logic [fprint_width-1:0] fp_mem [fprint_pkg::task_count][3];
	logic [2:0]              present [fprint_pkg::task_count];
	// nmr flag seen when the task's last fingerprint arrived
	logic [fprint_pkg::task_count-1:0] task_nmr;
	logic [fprint_pkg::task_count-1:0] complete;

	logic                                    found;
	logic [fprint_pkg::task_id_width-1:0]    sel_task;
	logic                                    vote_mismatch;
	logic [fprint_pkg::logical_id_width-1:0] vote_logical;
	logic                                    store;
	logic                                    eq_01, eq_02, eq_12;

	// report lookup only when no fingerprint needs the table
	assign lookup_task_id = (state == fprint_pkg::cmp_report && !fprint_valid) ?
		status_task_id : fprint_task_id;
	assign lookup_core_id = fprint_core_id;
	assign store = fprint_valid && (lookup_logical_id != fprint_pkg::logical_unassigned);

	always_ff @(posedge clk) begin
		if (store) begin
			fp_mem[fprint_task_id][lookup_logical_id] <= fprint_data;
			task_nmr[fprint_task_id] <= comparator_nmr;
		end
	end

	always_comb begin
		found = 1'b0;
		sel_task = '0;
		for (int t = fprint_pkg::task_count - 1; t >= 0; t--) begin
			complete[t] = present[t][0] && present[t][1] && (present[t][2] || !task_nmr[t]);
			if (complete[t]) begin
				found = 1'b1;
				sel_task = t[fprint_pkg::task_id_width-1:0];
			end
		end
	end

	// vote on the selected task
	assign eq_01 = (fp_mem[sel_task][0] == fp_mem[sel_task][1]);
	assign eq_02 = (fp_mem[sel_task][0] == fp_mem[sel_task][2]);
	assign eq_12 = (fp_mem[sel_task][1] == fp_mem[sel_task][2]);

	always_comb begin
		vote_mismatch = 1'b1;
		vote_logical = fprint_pkg::logical_unassigned;
		if (!task_nmr[sel_task]) begin
			vote_mismatch = !eq_01;
		end else if (eq_01 && eq_02) begin
			vote_mismatch = 1'b0;
		end else if (eq_01) begin
			vote_logical = 2'd2;
		end else if (eq_02) begin
			vote_logical = 2'd1;
		end else if (eq_12) begin
			vote_logical = 2'd0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == fprint_pkg::cmp_scan && found) begin
			status_task_id <= sel_task;
			status_mismatch <= vote_mismatch;
			status_logical_id <= vote_logical;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fprint_pkg::cmp_scan;
			status_write <= 1'b0;
			for (int t = 0; t < fprint_pkg::task_count; t++) begin
				present[t] <= '0;
			end
		end else begin
			if (state == fprint_pkg::cmp_scan && found) begin
				state <= fprint_pkg::cmp_report;
				status_write <= 1'b1;
			end else if (state == fprint_pkg::cmp_report && csr_status_ack) begin
				state <= fprint_pkg::cmp_scan;
				status_write <= 1'b0;
				present[status_task_id] <= '0;
			end
			// a new fingerprint outranks the clear on the ack edge
			if (store) begin
				present[fprint_task_id][lookup_logical_id] <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/fprint_compare_top.sv
module fprint_compare_top #(
	parameter int fprint_width = 32
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [fprint_pkg::csr_addr_width-1:0] csr_address,
	input  logic                                  csr_read,
	input  logic                                  csr_write,
	input  logic [fprint_pkg::data_width-1:0]     csr_writedata,
	output logic [fprint_pkg::data_width-1:0]     csr_readdata,
	output logic                                  csr_waitrequest,
	input  logic                                  fprint_valid,
	input  logic [fprint_pkg::task_id_width-1:0]  fprint_task_id,
	input  logic [fprint_pkg::core_id_width-1:0]  fprint_core_id,
	input  logic [fprint_width-1:0]               fprint_data,
	output logic                                  irq
);

	logic [fprint_pkg::task_id_width-1:0]    lookup_task_id;
	logic [fprint_pkg::core_id_width-1:0]    lookup_core_id;
	logic [fprint_pkg::logical_id_width-1:0] lookup_logical_id;
	logic                                    comparator_nmr;
	logic                                    status_write;
	logic [fprint_pkg::task_id_width-1:0]    status_task_id;
	logic                                    status_mismatch;
	logic [fprint_pkg::logical_id_width-1:0] status_logical_id;
	logic                                    csr_status_ack;

	csr_registers csr (
		.clk(clk), .reset(reset),
		.csr_address(csr_address), .csr_read(csr_read), .csr_write(csr_write),
		.csr_writedata(csr_writedata), .csr_readdata(csr_readdata),
		.csr_waitrequest(csr_waitrequest),
		.lookup_task_id(lookup_task_id), .lookup_core_id(lookup_core_id),
		.lookup_logical_id(lookup_logical_id), .comparator_nmr(comparator_nmr),
		.status_write(status_write), .status_task_id(status_task_id),
		.status_mismatch(status_mismatch), .status_logical_id(status_logical_id),
		.csr_status_ack(csr_status_ack), .irq(irq)
	);

	fprint_comparator #(.fprint_width(fprint_width)) comparator (
		.clk(clk), .reset(reset),
		.fprint_valid(fprint_valid), .fprint_task_id(fprint_task_id),
		.fprint_core_id(fprint_core_id), .fprint_data(fprint_data),
		.lookup_task_id(lookup_task_id), .lookup_core_id(lookup_core_id),
		.lookup_logical_id(lookup_logical_id), .comparator_nmr(comparator_nmr),
		.status_write(status_write), .status_task_id(status_task_id),
		.status_mismatch(status_mismatch), .status_logical_id(status_logical_id),
		.csr_status_ack(csr_status_ack)
	);

endmodule

// File: rtl/fprint_pkg.sv
package fprint_pkg;

	// host port
	localparam int data_width = 32;
	localparam int csr_addr_width = 4;

	// task and core ids
	localparam int task_id_width = 4;
	localparam int task_count = 16;
	localparam int core_id_width = 4;
	localparam int logical_id_width = 2;
	localparam logic [logical_id_width-1:0] logical_unassigned = 2'd3;

	typedef enum logic [csr_addr_width-1:0] {
		reg_exception = 4'd0,
		reg_success = 4'd1,
		reg_fail = 4'd2,
		reg_core_assign = 4'd3,
		reg_nmr = 4'd4
	} csr_reg_e;

	// exception register layout, task id in bits 7:4
	localparam int exc_irq_bit = 0;
	localparam int exc_mismatch_bit = 1;
	localparam int exc_task_lsb = 4;

	// fields of a core assignment or nmr write word
	localparam int wr_task_lsb = 16;
	localparam int wr_logical_lsb = 24;
	localparam int wr_physical_lsb = 0;

	typedef enum logic [2:0] {
		csr_idle,
		csr_regs_write,
		csr_assign_write,
		csr_nmr_write,
		csr_read,
		csr_done,
		status_capture,
		status_ack
	} csr_state_e;

	typedef enum logic {cmp_scan, cmp_report} cmp_state_e;

endpackage

// File: verification/fprint_checker.sv
module fprint_checker (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              csr_read,
	input  logic                              csr_write,
	input  logic                              csr_waitrequest,
	input  logic [fprint_pkg::data_width-1:0] csr_readdata,
	input  logic                              irq,
	input  logic [fprint_pkg::data_width-1:0] read_expected,
	input  logic [fprint_pkg::data_width-1:0] read_mask,
	input  logic                              irq_check,
	input  logic                              irq_expected,
	output int                                error_count
);

	// idle cycle plus one decode or read cycle before csr_done
	localparam int wait_expected = 2;

	int wait_cycles;

	initial begin
		error_count = 0;
		wait_cycles = 0;
	end

	always @(posedge clk) begin
		if (!reset && (csr_read || csr_write)) begin
			if (csr_waitrequest) begin
				wait_cycles++;
			end else begin
				if (wait_cycles != wait_expected) begin
					$display("ERROR csr_waitrequest: low after %h cycles expected %h",
						wait_cycles, wait_expected);
					error_count++;
				end
				wait_cycles = 0;
				// read data is valid in csr_done while the request is still held
				if (csr_read && (csr_readdata & read_mask) !== (read_expected & read_mask)) begin
					$display("ERROR csr_readdata: got %h expected %h (mask %h)",
						csr_readdata, read_expected, read_mask);
					error_count++;
				end
			end
		end
		if (!reset && irq_check) begin
			if (irq !== irq_expected) begin
				$display("ERROR irq: got %h expected %h", irq, irq_expected);
				error_count++;
			end
		end
	end

endmodule

// File: verification/tb_fprint_compare.sv
module tb_fprint_compare;

	localparam int op_write = 0;
	localparam int op_read = 1;
	localparam int op_fprint = 2;
	localparam int op_irq = 3;
	localparam int op_idle = 4;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic [3:0]  csr_address = '0;
	logic        csr_read = 1'b0;
	logic        csr_write = 1'b0;
	logic [31:0] csr_writedata = '0;
	logic [31:0] csr_readdata;
	logic        csr_waitrequest;
	logic        fprint_valid = 1'b0;
	logic [3:0]  fprint_task_id = '0;
	logic [3:0]  fprint_core_id = '0;
	logic [31:0] fprint_data = '0;
	logic        irq;
	logic [31:0] read_expected = '0;
	logic [31:0] read_mask = '0;
	logic        irq_check = 1'b0;
	logic        irq_expected = 1'b0;
	int          error_count;

	// fingerprint rows keep the task id in row_addr
	int          row_op[$];
	logic [3:0]  row_addr[$];
	logic [31:0] row_data[$];
	logic [31:0] row_mask[$];
	logic [3:0]  row_core[$];

	integer      seed = 32'h4571;
	int          cycle_count = 0;
	int          cycle_limit = 100000;

	fprint_compare_top #(.fprint_width(32)) uut (
		.clk(clk), .reset(reset),
		.csr_address(csr_address), .csr_read(csr_read), .csr_write(csr_write),
		.csr_writedata(csr_writedata), .csr_readdata(csr_readdata),
		.csr_waitrequest(csr_waitrequest),
		.fprint_valid(fprint_valid), .fprint_task_id(fprint_task_id),
		.fprint_core_id(fprint_core_id), .fprint_data(fprint_data), .irq(irq)
	);

	fprint_checker result_check (
		.clk(clk), .reset(reset), .csr_read(csr_read), .csr_write(csr_write),
		.csr_waitrequest(csr_waitrequest),
		.csr_readdata(csr_readdata), .irq(irq), .read_expected(read_expected),
		.read_mask(read_mask), .irq_check(irq_check), .irq_expected(irq_expected),
		.error_count(error_count)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic add_row(input int op, input logic [3:0] addr, input logic [31:0] data,
		input logic [31:0] mask, input logic [3:0] core);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_mask.push_back(mask);
		row_core.push_back(core);
	endtask

	function automatic logic [31:0] assign_word(input logic [3:0] task_id,
		input logic [1:0] slot, input logic [3:0] core);
		logic [31:0] w;
		w = '0;
		w[fprint_pkg::wr_task_lsb +: 4] = task_id;
		w[fprint_pkg::wr_logical_lsb +: 2] = slot;
		w[fprint_pkg::wr_physical_lsb +: 4] = core;
		return w;
	endfunction

	// expected exception word after a report
	function automatic logic [31:0] exc_word(input logic [3:0] task_id, input logic mismatch);
		logic [31:0] w;
		w = '0;
		w[fprint_pkg::exc_irq_bit] = 1'b1;
		w[fprint_pkg::exc_mismatch_bit] = mismatch;
		w[fprint_pkg::exc_task_lsb +: 4] = task_id;
		return w;
	endfunction

	task automatic wait_ready;
		@(negedge clk);
		while (csr_waitrequest) begin
			@(negedge clk);
		end
		// drop the request one cycle after done
		@(negedge clk);
		csr_read = 1'b0;
		csr_write = 1'b0;
	endtask

	task automatic apply_row(input int i);
		int n;
		case (row_op[i])
			op_write: begin
				csr_address = row_addr[i];
				csr_writedata = row_data[i];
				csr_write = 1'b1;
				wait_ready();
			end
			op_read: begin
				csr_address = row_addr[i];
				read_expected = row_data[i];
				read_mask = row_mask[i];
				csr_read = 1'b1;
				wait_ready();
			end
			op_fprint: begin
				fprint_task_id = row_addr[i];
				fprint_core_id = row_core[i];
				fprint_data = row_data[i];
				fprint_valid = 1'b1;
				@(negedge clk);
				fprint_valid = 1'b0;
			end
			op_irq: begin
				n = 0;
				while (irq !== row_data[i][0] && n < 30) begin
					@(negedge clk);
					n++;
				end
				irq_expected = row_data[i][0];
				irq_check = 1'b1;
				@(negedge clk);
				irq_check = 1'b0;
			end
			default: begin
				repeat (row_data[i]) @(negedge clk);
			end
		endcase
	endtask

	initial begin
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] r4;
		logic [31:0] r5;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		r4 = $random(seed);
		r5 = $random(seed);

		// reset values
		add_row(op_read, fprint_pkg::reg_exception, 32'h0, 32'hffffffff, 4'd0);
		add_row(op_read, fprint_pkg::reg_success, 32'h0, 32'hffffffff, 4'd0);
		add_row(op_read, fprint_pkg::reg_fail, 32'hffffffff, 32'hffffffff, 4'd0);
		add_row(op_irq, 4'd0, 32'd0, 32'd0, 4'd0);
		// dual match on task 2
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd2, 2'd0, 4'd1), 0, 0);
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd2, 2'd1, 4'd5), 0, 0);
		add_row(op_fprint, 4'd2, r1, 32'd0, 4'd1);
		add_row(op_fprint, 4'd2, r1, 32'd0, 4'd5);
		add_row(op_irq, 4'd0, 32'd1, 32'd0, 4'd0);
		add_row(op_read, fprint_pkg::reg_exception, exc_word(4'd2, 1'b0), 32'hffffffff, 0);
		add_row(op_read, fprint_pkg::reg_success, 32'h4, 32'h4, 4'd0);
		// clear
		add_row(op_write, fprint_pkg::reg_exception, 32'h0, 32'd0, 4'd0);
		add_row(op_irq, 4'd0, 32'd0, 32'd0, 4'd0);
		add_row(op_read, fprint_pkg::reg_success, 32'h0, 32'hffffffff, 4'd0);
		add_row(op_read, fprint_pkg::reg_fail, 32'hffffffff, 32'hffffffff, 4'd0);
		// triple vote on task 7 with slot 1 dissenting
		add_row(op_write, fprint_pkg::reg_nmr, assign_word(4'd7, 2'd0, 4'd1), 0, 0);
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd7, 2'd0, 4'd2), 0, 0);
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd7, 2'd1, 4'd3), 0, 0);
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd7, 2'd2, 4'd4), 0, 0);
		add_row(op_fprint, 4'd7, r2, 32'd0, 4'd2);
		add_row(op_fprint, 4'd7, r2 ^ 32'h1, 32'd0, 4'd3);
		add_row(op_fprint, 4'd7, r2, 32'd0, 4'd4);
		add_row(op_irq, 4'd0, 32'd1, 32'd0, 4'd0);
		add_row(op_read, fprint_pkg::reg_exception, exc_word(4'd7, 1'b1), 32'hffffffff, 0);
		add_row(op_read, fprint_pkg::reg_success, 32'h0, 32'h80, 4'd0);
		add_row(op_read, fprint_pkg::reg_fail, 32'h4000, 32'hc000, 4'd0);
		add_row(op_write, fprint_pkg::reg_exception, 32'h0, 32'd0, 4'd0);
		// dual mismatch on task 8 keeps its fail field at 3
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd8, 2'd0, 4'd6), 0, 0);
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd8, 2'd1, 4'd7), 0, 0);
		add_row(op_fprint, 4'd8, r3, 32'd0, 4'd6);
		add_row(op_fprint, 4'd8, r3 ^ 32'h100, 32'd0, 4'd7);
		add_row(op_irq, 4'd0, 32'd1, 32'd0, 4'd0);
		add_row(op_read, fprint_pkg::reg_exception, exc_word(4'd8, 1'b1), 32'hffffffff, 0);
		add_row(op_read, fprint_pkg::reg_fail, 32'h30000, 32'h30000, 4'd0);
		// tasks 3 and 4 complete while irq is still high
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd3, 2'd0, 4'd1), 0, 0);
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd3, 2'd1, 4'd2), 0, 0);
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd4, 2'd0, 4'd3), 0, 0);
		add_row(op_write, fprint_pkg::reg_core_assign, assign_word(4'd4, 2'd1, 4'd5), 0, 0);
		add_row(op_fprint, 4'd4, r5, 32'd0, 4'd3);
		add_row(op_fprint, 4'd3, r4, 32'd0, 4'd1);
		add_row(op_fprint, 4'd3, r4, 32'd0, 4'd2);
		add_row(op_fprint, 4'd4, r5, 32'd0, 4'd5);
		add_row(op_idle, 4'd0, 32'd10, 32'd0, 4'd0);
		add_row(op_read, fprint_pkg::reg_exception, exc_word(4'd8, 1'b1), 32'hffffffff, 0);
		add_row(op_write, fprint_pkg::reg_exception, 32'h0, 32'd0, 4'd0);
		add_row(op_irq, 4'd0, 32'd1, 32'd0, 4'd0);
		add_row(op_read, fprint_pkg::reg_exception, exc_word(4'd3, 1'b0), 32'hffffffff, 0);
		add_row(op_write, fprint_pkg::reg_exception, 32'h0, 32'd0, 4'd0);
		add_row(op_irq, 4'd0, 32'd1, 32'd0, 4'd0);
		add_row(op_read, fprint_pkg::reg_exception, exc_word(4'd4, 1'b0), 32'hffffffff, 0);
		add_row(op_write, fprint_pkg::reg_exception, 32'h0, 32'd0, 4'd0);
		// core 9 is not in task 10's table
		add_row(op_fprint, 4'd10, r1, 32'd0, 4'd9);
		add_row(op_idle, 4'd0, 32'd20, 32'd0, 4'd0);
		add_row(op_irq, 4'd0, 32'd0, 32'd0, 4'd0);
		add_row(op_read, fprint_pkg::reg_exception, 32'h0, 32'hffffffff, 4'd0);

		cycle_limit = 8 + 40 * row_op.size();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < row_op.size(); i++) begin
			apply_row(i);
		end
		repeat (2) @(negedge clk);

		$display("errors: %0d", error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
